/* dv/core_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module core_tb;
    import core_isa_pkg::*;
    import core_pipe_pkg::*;

    localparam int tb_core_id = 5;
    localparam int max_cycles = 4000;

    logic        clk;
    logic        rst_n;
    base_dcrs_t  dcr_base;
    icache_req_t icache_req;
    icache_rsp_t icache_rsp;
    dcache_req_t dcache_req;
    dcache_rsp_t dcache_rsp;
    logic        sim_ebreak;
    logic        busy;
    logic [num_regs-1:0][xlen-1:0] sim_wb_value;

    logic [31:0] prog_mem [1024];
    logic [31:0] data_init [1024];
    logic [31:0] ref_dmem [1024];
    logic [31:0] ref_regs [16];
    logic [31:0] rnd;
    int          emit_idx;

    core_top #(
        .core_id      (tb_core_id)
    ) dut0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .dcr_base     (dcr_base),
        .icache_req   (icache_req),
        .icache_rsp   (icache_rsp),
        .dcache_req   (dcache_req),
        .dcache_rsp   (dcache_rsp),
        .sim_ebreak   (sim_ebreak),
        .sim_wb_value (sim_wb_value),
        .busy         (busy)
    );

    tb_mem_model mem0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .icache_req (icache_req),
        .icache_rsp (icache_rsp),
        .dcache_req (dcache_req),
        .dcache_rsp (dcache_rsp),
        .imem_init  (prog_mem),
        .dmem_init  (data_init)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] enc_r(input logic [3:0] fn, rd, rs1, rs2);
        return {4'(op_alu), rd, rs1, rs2, 12'h000, fn};
    endfunction

    function automatic logic [31:0] enc_i(input logic [3:0] op, rd, rs1,
                                          input logic [19:0] imm);
        return {op, rd, rs1, imm};
    endfunction

    task automatic abort(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_equal(input string name, input logic [31:0] expected, actual);
        assert (expected === actual) else begin
            $display("ERR time=%0t %s expected=%h actual=%h", $time, name, expected, actual);
            $display("TESTS FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_idle();
        check_equal("icache_req.valid", 32'd0, 32'(icache_req.valid));
        check_equal("dcache_req.valid", 32'd0, 32'(dcache_req.valid));
        check_equal("sim_ebreak", 32'd0, 32'(sim_ebreak));
        check_equal("busy", 32'd0, 32'(busy));
    endtask

    task automatic emit(input logic [31:0] word);
        prog_mem[emit_idx] = word;
        emit_idx++;
    endtask

    task automatic start_build(input logic [31:0] start_pc);
        for (int k = 0; k < 1024; k++) begin
            prog_mem[k] = '0;
        end
        emit_idx = int'(start_pc[11:2]);
    endtask

    // **************************************************
    // ISA interpreter for the expected machine state.
    // **************************************************
    task automatic interpret(input logic [31:0] start_pc);
        logic [31:0] pc;
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] addr;
        int          count;
        logic        done;
        for (int k = 0; k < 16; k++) begin
            ref_regs[k] = '0;
        end
        for (int k = 0; k < 1024; k++) begin
            ref_dmem[k] = data_init[k];
        end
        pc    = start_pc;
        count = 0;
        done  = 1'b0;
        for (int step = 0; step < max_cycles && !done; step++) begin
            w    = prog_mem[pc[11:2]];
            a    = ref_regs[w[23:20]];
            b    = ref_regs[w[19:16]];
            imm  = {{12{w[19]}}, w[19:0]};
            addr = a + imm;
            pc   = pc + 32'd4;
            case (w[31:28])
                4'(op_alu): begin
                    case (w[3:0])
                        4'd0: ref_regs[w[27:24]] = a + b;
                        4'd1: ref_regs[w[27:24]] = a - b;
                        4'd2: ref_regs[w[27:24]] = a & b;
                        4'd3: ref_regs[w[27:24]] = a | b;
                        4'd4: ref_regs[w[27:24]] = a ^ b;
                        4'd5: ref_regs[w[27:24]] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: ref_regs[w[27:24]] = '0;
                    endcase
                end
                4'(op_addi): ref_regs[w[27:24]] = addr;
                4'(op_lw):   ref_regs[w[27:24]] = ref_dmem[addr[11:2]];
                4'(op_sw):   ref_dmem[addr[11:2]] = ref_regs[w[27:24]];
                4'(op_bne): begin
                    if (a != ref_regs[w[27:24]]) begin
                        pc = pc - 32'd4 + (imm << 2);
                    end
                end
                4'(op_csrr): begin
                    if (w[19:0] == csr_core_id) ref_regs[w[27:24]] = tb_core_id;
                    else if (w[19:0] == csr_instret) ref_regs[w[27:24]] = 32'(count);
                    else ref_regs[w[27:24]] = '0;
                end
                default: done = 1'b1;  // Ebreak.
            endcase
            count++;
        end
        if (!done) abort("reference interpreter never reached ebreak");
    endtask

    task automatic build_alu(input logic [31:0] start_pc);
        logic [3:0] last_rd;
        start_build(start_pc);
        for (int k = 1; k <= 6; k++) begin
            rnd = xorshift32(rnd);
            emit(enc_i(4'(op_addi), 4'(k), 4'd0, rnd[19:0]));
        end
        last_rd = 4'd6;
        for (int k = 0; k < 30; k++) begin
            rnd = xorshift32(rnd);
            if (k > 5 && k % 5 == 4) begin
                emit(enc_i(4'(op_addi), rnd[7:4], last_rd, rnd[31:12]));
            end else begin
                // Source is the previous destination, so hazards are back to back.
                emit(enc_r((k < 6) ? 4'(k) : 4'(rnd % 6), rnd[7:4], last_rd, rnd[11:8]));
            end
            last_rd = rnd[7:4];
        end
        emit({4'(op_ebreak), 28'h0});
    endtask

    task automatic build_mem(input logic [31:0] start_pc);
        logic [19:0] addrs [6];
        start_build(start_pc);
        for (int k = 1; k <= 4; k++) begin
            rnd = xorshift32(rnd);
            emit(enc_i(4'(op_addi), 4'(k), 4'd0, rnd[19:0]));
        end
        rnd = xorshift32(rnd);
        emit(enc_i(4'(op_addi), 4'd5, 4'd0, {8'h00, rnd[11:2], 2'b00}));
        for (int k = 0; k < 6; k++) begin
            rnd = xorshift32(rnd);
            addrs[k] = {8'h00, rnd[11:2], 2'b00};
            emit(enc_i(4'(op_sw), 4'(1 + k % 4), 4'd0, addrs[k]));
        end
        emit(enc_i(4'(op_csrr), 4'd8, 4'd0, csr_instret));
        for (int k = 0; k < 6; k++) begin
            emit(enc_i(4'(op_lw), 4'(9 + k), 4'd0, addrs[5 - k]));
        end
        emit(enc_i(4'(op_lw), 4'd15, 4'd5, 20'd8));
        emit(enc_i(4'(op_csrr), 4'd7, 4'd0, csr_core_id));
        emit(enc_i(4'(op_csrr), 4'd6, 4'd0, 20'h00123));  // Unknown CSR.
        emit({4'(op_ebreak), 28'h0});
    endtask

    task automatic build_branch(input logic [31:0] start_pc);
        start_build(start_pc);
        emit(enc_i(4'(op_addi), 4'd1, 4'd0, 20'd5));
        emit(enc_i(4'(op_addi), 4'd2, 4'd2, 20'd7));         // Loop body.
        emit(enc_i(4'(op_addi), 4'd1, 4'd1, 20'hfffff));
        emit(enc_i(4'(op_bne), 4'd0, 4'd1, 20'hffffe));      // Back two words.
        emit(enc_i(4'(op_bne), 4'd0, 4'd2, 20'd2));          // Taken and skips one.
        emit(enc_i(4'(op_addi), 4'd4, 4'd0, 20'd99));
        emit(enc_i(4'(op_addi), 4'd5, 4'd0, 20'd11));
        emit(enc_i(4'(op_bne), 4'd0, 4'd1, 20'd2));          // Not taken.
        emit(enc_i(4'(op_addi), 4'd6, 4'd0, 20'd22));
        emit(enc_i(4'(op_csrr), 4'd7, 4'd0, csr_instret));
        emit(enc_i(4'(op_csrr), 4'd8, 4'd0, csr_core_id));
        emit({4'(op_ebreak), 28'h0});
    endtask

    task automatic run_program(input logic [31:0] start_pc);
        int cyc;
        @(posedge clk);
        rst_n             <= 1'b0;
        dcr_base.start_pc <= start_pc;
        interpret(start_pc);
        repeat (2) begin
            @(negedge clk);
            check_idle();
            @(posedge clk);
        end
        rst_n <= 1'b1;
        @(negedge clk);
        check_idle();  // First cycle out of reset.
        cyc = 0;
        while (!icache_req.valid) begin
            @(negedge clk);
            cyc++;
            if (cyc > 50) abort("no instruction request after reset");
        end
        check_equal("icache_req.addr", {2'b00, start_pc[31:2]}, {2'b00, icache_req.addr});
        cyc = 0;
        while (!sim_ebreak) begin
            @(negedge clk);
            cyc++;
            if (cyc > max_cycles) abort("timeout waiting for sim_ebreak");
        end
        repeat (2) @(negedge clk);  // Last writeback reaches the register file.
        for (int r = 0; r < num_regs; r++) begin
            check_equal($sformatf("sim_wb_value[%0d]", r), ref_regs[r], sim_wb_value[r]);
        end
        for (int d = 0; d < 1024; d++) begin
            check_equal($sformatf("dmem[%0d]", d), ref_dmem[d], mem0.dmem[d]);
        end
    endtask

    initial begin
        rst_n    <= 1'b0;
        dcr_base <= '0;
        rnd = 32'hd26d;
        for (int k = 0; k < 1024; k++) begin
            data_init[k] = (32'(k) * 32'h9e3779b9) ^ 32'h5a5a0000;
            prog_mem[k]  = '0;
        end

        build_alu(32'h0000_0100);
        run_program(32'h0000_0100);
        build_mem(32'h0000_0800);
        run_program(32'h0000_0800);
        build_branch(32'h0000_0400);
        run_program(32'h0000_0400);

        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* dv/tb_mem_model.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_mem_model (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire core_pipe_pkg::icache_req_t  icache_req,
    output core_pipe_pkg::icache_rsp_t   icache_rsp,
    input  wire core_pipe_pkg::dcache_req_t  dcache_req,
    output core_pipe_pkg::dcache_rsp_t   dcache_rsp,
    input  wire [31:0]                   imem_init [1024],
    input  wire [31:0]                   dmem_init [1024]
);
    logic [31:0] dmem [1024];
    logic [31:0] seed;
    logic [2:0]  i_cnt;   // Cycles left until the response or 0 when idle.
    logic [2:0]  d_cnt;
    logic [9:0]  i_addr;
    logic [9:0]  d_addr;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            seed = 32'hd26d;
            icache_rsp <= '0;
            dcache_rsp <= '0;
            i_cnt      <= '0;
            d_cnt      <= '0;
            i_addr     <= '0;
            d_addr     <= '0;
            for (int k = 0; k < 1024; k++) begin
                dmem[k] <= dmem_init[k];
            end
        end else begin
            icache_rsp.valid <= 1'b0;
            dcache_rsp.valid <= 1'b0;

            if (icache_req.valid) begin
                seed = xorshift32(seed);
                i_cnt  <= 3'(seed % 6) + 3'd1;  // Latency of 1 to 6 cycles.
                i_addr <= icache_req.addr[9:0];
            end else if (i_cnt == 3'd1) begin
                icache_rsp <= {1'b1, imem_init[i_addr]};
                i_cnt      <= '0;
            end else if (i_cnt != 3'd0) begin
                i_cnt <= i_cnt - 3'd1;
            end

            if (dcache_req.valid) begin
                seed = xorshift32(seed);
                d_cnt  <= 3'(seed % 6) + 3'd1;
                d_addr <= dcache_req.addr[9:0];
                if (dcache_req.write) begin
                    dmem[dcache_req.addr[9:0]] <= dcache_req.wdata;
                end
            end else if (d_cnt == 3'd1) begin
                dcache_rsp <= {1'b1, dmem[d_addr]};
                d_cnt      <= '0;
            end else if (d_cnt != 3'd0) begin
                d_cnt <= d_cnt - 3'd1;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/core_commit.sv */
`timescale 1ns/10ps
`default_nettype none

module core_commit (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire core_pipe_pkg::commit_t     alu_commit,
    input  wire core_pipe_pkg::commit_t     ld_commit,
    input  wire                         st_done,
    output core_pipe_pkg::commit_t      writeback,
    output logic [core_isa_pkg::xlen-1:0] instret
);
    import core_isa_pkg::*;
    import core_pipe_pkg::*;

    commit_t nxt;

    // At most one unit is valid in any cycle.
    always_comb begin
        nxt = '0;
        if (alu_commit.valid) begin
            nxt = alu_commit;
        end else if (ld_commit.valid) begin
            nxt = ld_commit;
        end else if (st_done) begin
            nxt.valid = 1'b1;  // A store retires and writes nothing.
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            writeback <= '0;
            instret   <= '0;
        end else begin
            writeback <= nxt;
            if (nxt.valid) begin
                instret <= instret + xlen'(1);
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/core_decode.sv */
`timescale 1ns/10ps
`default_nettype none

module core_decode (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire core_pipe_pkg::fetch_rsp_t  fetch_rsp,
    input  wire                         stall,
    output core_pipe_pkg::decode_t      decode
);
    import core_isa_pkg::*;
    import core_pipe_pkg::*;

    instr_u  word;
    decode_t d_next;

    assign word = fetch_rsp.instr;

    always_comb begin
        d_next        = '0;
        d_next.valid  = fetch_rsp.valid;
        d_next.pc     = fetch_rsp.pc;
        d_next.opcode = word.r.opcode;
        d_next.fn     = word.r.fn;
        d_next.rd     = word.r.rd;
        d_next.rs1    = word.r.rs1;
        d_next.rs2    = word.r.rs1;  // Unused second source repeats rs1.
        d_next.imm    = {{(xlen-20){word.i.imm20[19]}}, word.i.imm20};
        case (word.r.opcode)
            op_alu: begin
                d_next.rs2 = word.r.rs2;
                d_next.wb  = 1'b1;
            end
            op_sw, op_bne: begin
                d_next.rs2 = word.i.rd;  // Store data or compare source.
            end
            op_addi, op_lw, op_csrr: begin
                d_next.wb = 1'b1;
            end
            default: begin
                d_next.wb = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            decode <= '0;
        end else if (!stall) begin
            decode <= d_next;
        end
    end

endmodule

`default_nettype wire

/* rtl/core_execute.sv */
`timescale 1ns/10ps
`default_nettype none

module core_execute #(
    parameter int core_id = 0
) (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire core_pipe_pkg::exec_req_t   exec_req,
    input  wire [core_isa_pkg::xlen-1:0]    instret,
    output core_pipe_pkg::dcache_req_t  dcache_req,
    input  wire core_pipe_pkg::dcache_rsp_t dcache_rsp,
    output core_pipe_pkg::branch_ctl_t  branch_ctl,
    output core_pipe_pkg::commit_t      alu_commit,
    output core_pipe_pkg::commit_t      ld_commit,
    output logic                        st_done,
    output logic                        busy,
    output logic                        sim_ebreak
);
    import core_isa_pkg::*;

    logic            is_ls;
    logic            is_mem;
    logic [xlen-1:0] alu_res;
    logic [xlen-1:0] csr_res;
    logic [xlen-1:0] result;
    logic [xlen-1:0] mem_addr;
    logic            lsu_pending;
    logic            lsu_write;
    reg_idx_t        lsu_rd;

    assign is_ls    = (exec_req.opcode == op_lw) || (exec_req.opcode == op_sw);
    assign is_mem   = exec_req.valid && is_ls;
    assign busy     = lsu_pending || is_mem;
    assign mem_addr = exec_req.opa + exec_req.imm;

    always_comb begin
        case (exec_req.fn)
            fn_add:  alu_res = exec_req.opa + exec_req.opb;
            fn_sub:  alu_res = exec_req.opa - exec_req.opb;
            fn_and:  alu_res = exec_req.opa & exec_req.opb;
            fn_or:   alu_res = exec_req.opa | exec_req.opb;
            fn_xor:  alu_res = exec_req.opa ^ exec_req.opb;
            fn_slt:  alu_res = xlen'($signed(exec_req.opa) < $signed(exec_req.opb));
            default: alu_res = '0;
        endcase
    end

    // An instruction still in alu_commit has not reached instret yet.
    always_comb begin
        case (exec_req.imm[19:0])
            csr_core_id: csr_res = xlen'(core_id);
            csr_instret: csr_res = instret + xlen'(alu_commit.valid);
            default:     csr_res = '0;
        endcase
    end

    always_comb begin
        case (exec_req.opcode)
            op_addi: result = exec_req.opa + exec_req.imm;
            op_csrr: result = csr_res;
            default: result = alu_res;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            alu_commit  <= '0;
            branch_ctl  <= '0;
            dcache_req  <= '0;
            ld_commit   <= '0;
            st_done     <= 1'b0;
            lsu_pending <= 1'b0;
            lsu_write   <= 1'b0;
            lsu_rd      <= '0;
            sim_ebreak  <= 1'b0;
        end else begin
            alu_commit.valid <= exec_req.valid && !is_ls;
            alu_commit.rd    <= exec_req.rd;
            alu_commit.wb    <= exec_req.wb;
            alu_commit.data  <= result;

            branch_ctl.valid  <= exec_req.valid && (exec_req.opcode == op_bne);
            branch_ctl.taken  <= exec_req.opa != exec_req.opb;
            branch_ctl.target <= exec_req.pc + {exec_req.imm[xlen-3:0], 2'b00};

            if (exec_req.valid && exec_req.opcode == op_ebreak) begin
                sim_ebreak <= 1'b1;  // Sticky until reset.
            end

            // **************************************************
            // Load/store unit, one access at a time.
            // **************************************************
            dcache_req.valid <= is_mem;
            if (is_mem) begin
                dcache_req.write <= exec_req.opcode == op_sw;
                dcache_req.addr  <= mem_addr[xlen-1:2];
                dcache_req.wdata <= exec_req.opb;
                lsu_pending      <= 1'b1;
                lsu_write        <= exec_req.opcode == op_sw;
                lsu_rd           <= exec_req.rd;
            end

            ld_commit.valid <= 1'b0;
            st_done         <= 1'b0;
            if (lsu_pending && dcache_rsp.valid) begin
                lsu_pending     <= 1'b0;
                ld_commit.valid <= !lsu_write;
                ld_commit.rd    <= lsu_rd;
                ld_commit.wb    <= 1'b1;
                ld_commit.data  <= dcache_rsp.data;
                st_done         <= lsu_write;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/core_fetch.sv */
`timescale 1ns/10ps
`default_nettype none

module core_fetch (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire core_pipe_pkg::base_dcrs_t  base_dcrs,
    output core_pipe_pkg::icache_req_t  icache_req,
    input  wire core_pipe_pkg::icache_rsp_t icache_rsp,
    input  wire                         stall,
    input  wire core_pipe_pkg::branch_ctl_t branch_ctl,
    output core_pipe_pkg::fetch_rsp_t   fetch_rsp,
    output logic                        busy
);
    import core_isa_pkg::*;

    logic            pc_loaded;
    logic            pending;      // One request in flight.
    logic            branch_wait;
    logic            halted;
    logic [xlen-1:0] pc;
    instr_u          rsp_word;
    logic            req_go;

    assign rsp_word = icache_rsp.data;

    // Only request into an empty fetch_rsp, so a late response is never lost.
    assign req_go = pc_loaded && !pending && !branch_wait && !halted
                    && !stall && !fetch_rsp.valid;

    assign busy = (pc_loaded && !halted) || pending || fetch_rsp.valid || stall;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_loaded   <= 1'b0;
            pending     <= 1'b0;
            branch_wait <= 1'b0;
            halted      <= 1'b0;
            pc          <= '0;
            icache_req  <= '0;
            fetch_rsp   <= '0;
        end else begin
            if (!pc_loaded) begin
                pc        <= base_dcrs.start_pc;  // Start PC from the DCR.
                pc_loaded <= 1'b1;
            end else if (branch_ctl.valid && branch_ctl.taken) begin
                pc <= branch_ctl.target;
            end else if (req_go) begin
                pc <= pc + xlen'(4);
            end

            icache_req.valid <= req_go;
            if (req_go) begin
                icache_req.addr <= pc[xlen-1:2];
                pending         <= 1'b1;
            end else if (icache_rsp.valid) begin
                pending <= 1'b0;
            end

            if (icache_rsp.valid && pending) begin
                fetch_rsp.valid <= 1'b1;
                fetch_rsp.pc    <= {icache_req.addr, 2'b00};
                fetch_rsp.instr <= rsp_word;
                halted          <= halted || (rsp_word.r.opcode == op_ebreak);
            end else if (!stall) begin
                fetch_rsp.valid <= 1'b0;
            end

            // No fetch past a bne until execute resolves it.
            if (icache_rsp.valid && pending && rsp_word.r.opcode == op_bne) begin
                branch_wait <= 1'b1;
            end else if (branch_ctl.valid) begin
                branch_wait <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/core_isa_pkg.sv */
`default_nettype none

package core_isa_pkg;

    parameter int xlen     = 32;
    parameter int num_regs = 16;

    typedef logic [3:0] reg_idx_t;

    typedef enum logic [3:0] {
        op_alu    = 4'h0,
        op_addi   = 4'h1,
        op_lw     = 4'h2,
        op_sw     = 4'h3,
        op_bne    = 4'h4,
        op_csrr   = 4'h5,
        op_ebreak = 4'h6
    } opcode_e;

    typedef enum logic [3:0] {
        fn_add = 4'h0,
        fn_sub = 4'h1,
        fn_and = 4'h2,
        fn_or  = 4'h3,
        fn_xor = 4'h4,
        fn_slt = 4'h5  // Signed compare.
    } alu_fn_e;

    localparam logic [19:0] csr_core_id = 20'h00f14;
    localparam logic [19:0] csr_instret = 20'h00c02;

    // Register format.
    typedef struct packed {
        opcode_e    opcode;
        reg_idx_t   rd;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        logic [11:0] unused;
        alu_fn_e    fn;
    } r_fmt_t;

    // Immediate format, also used by lw, sw, bne and csrr.
    typedef struct packed {
        opcode_e     opcode;
        reg_idx_t    rd;
        reg_idx_t    rs1;
        logic [19:0] imm20;
    } i_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } instr_u;

endpackage

`default_nettype wire

/* rtl/core_issue.sv */
`timescale 1ns/10ps
`default_nettype none

module core_issue (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire core_pipe_pkg::decode_t    decode,
    input  wire                        exec_busy,
    input  wire core_pipe_pkg::commit_t    writeback,
    output logic                       stall,
    output core_pipe_pkg::exec_req_t   exec_req,
    output logic [core_isa_pkg::num_regs-1:0][core_isa_pkg::xlen-1:0] reg_values
);
    import core_isa_pkg::*;
    import core_pipe_pkg::*;

    decode_t             held;
    logic [num_regs-1:0] sb;      // Registers with a write in flight.
    logic                hazard;

    // RAW on both sources, WAW on the destination.
    assign hazard = sb[held.rs1] || sb[held.rs2] || (held.wb && sb[held.rd]);
    assign stall  = held.valid && (hazard || exec_busy);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            held       <= '0;
            exec_req   <= '0;
            sb         <= '0;
            reg_values <= '0;
        end else begin
            // **************************************************
            // Writeback port.
            // **************************************************
            if (writeback.valid && writeback.wb) begin
                reg_values[writeback.rd] <= writeback.data;
                sb[writeback.rd]         <= 1'b0;
            end

            // **************************************************
            // Operand read and dispatch.
            // **************************************************
            if (!stall) begin
                held           <= decode;
                exec_req.valid <= held.valid;
                exec_req.pc    <= held.pc;
                exec_req.opcode <= held.opcode;
                exec_req.fn    <= held.fn;
                exec_req.rd    <= held.rd;
                exec_req.opa   <= reg_values[held.rs1];
                exec_req.opb   <= reg_values[held.rs2];
                exec_req.imm   <= held.imm;
                exec_req.wb    <= held.wb;
                if (held.valid && held.wb) begin
                    sb[held.rd] <= 1'b1;
                end
            end else begin
                exec_req.valid <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/core_pipe_pkg.sv */
`default_nettype none

package core_pipe_pkg;

    import core_isa_pkg::*;

    typedef struct packed {
        logic [xlen-1:0] start_pc;
    } base_dcrs_t;

    // **************************************************
    // Memory ports.
    // **************************************************

    typedef struct packed {
        logic        valid;
        logic [29:0] addr;  // Word address.
    } icache_req_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] data;
    } icache_rsp_t;

    typedef struct packed {
        logic            valid;
        logic            write;
        logic [29:0]     addr;
        logic [xlen-1:0] wdata;
    } dcache_req_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] data;
    } dcache_rsp_t;

    // **************************************************
    // Stage records.
    // **************************************************

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        instr_u          instr;
    } fetch_rsp_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        opcode_e         opcode;
        alu_fn_e         fn;
        reg_idx_t        rd;
        reg_idx_t        rs1;
        reg_idx_t        rs2;
        logic [xlen-1:0] imm;
        logic            wb;
    } decode_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        opcode_e         opcode;
        alu_fn_e         fn;
        reg_idx_t        rd;
        logic [xlen-1:0] opa;
        logic [xlen-1:0] opb;  // Store data for sw.
        logic [xlen-1:0] imm;
        logic            wb;
    } exec_req_t;

    typedef struct packed {
        logic            valid;
        reg_idx_t        rd;
        logic            wb;
        logic [xlen-1:0] data;
    } commit_t;

    typedef struct packed {
        logic            valid;
        logic            taken;
        logic [xlen-1:0] target;
    } branch_ctl_t;

endpackage

`default_nettype wire

/* rtl/core_top.sv */
`timescale 1ns/10ps
`default_nettype none

module core_top #(
    parameter int core_id = 0
) (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire core_pipe_pkg::base_dcrs_t  dcr_base,
    output core_pipe_pkg::icache_req_t  icache_req,
    input  wire core_pipe_pkg::icache_rsp_t icache_rsp,
    output core_pipe_pkg::dcache_req_t  dcache_req,
    input  wire core_pipe_pkg::dcache_rsp_t dcache_rsp,
    output logic                        sim_ebreak,
    output logic [core_isa_pkg::num_regs-1:0][core_isa_pkg::xlen-1:0] sim_wb_value,
    output logic                        busy
);
    import core_isa_pkg::*;
    import core_pipe_pkg::*;

    base_dcrs_t      base_dcrs;
    fetch_rsp_t      fetch_rsp;
    decode_t         decode;
    exec_req_t       exec_req;
    branch_ctl_t     branch_ctl;
    commit_t         alu_commit;
    commit_t         ld_commit;
    commit_t         writeback;
    logic            st_done;
    logic            stall;
    logic            exec_busy;
    logic [xlen-1:0] instret;

    always_ff @(posedge clk) begin
        base_dcrs <= dcr_base;
    end

    core_fetch u_fetch (
        .clk        (clk),
        .rst_n      (rst_n),
        .base_dcrs  (base_dcrs),
        .icache_req (icache_req),
        .icache_rsp (icache_rsp),
        .stall      (stall),
        .branch_ctl (branch_ctl),
        .fetch_rsp  (fetch_rsp),
        .busy       (busy)
    );

    core_decode u_decode (
        .clk        (clk),
        .rst_n      (rst_n),
        .fetch_rsp  (fetch_rsp),
        .stall      (stall),
        .decode     (decode)
    );

    core_issue u_issue (
        .clk        (clk),
        .rst_n      (rst_n),
        .decode     (decode),
        .exec_busy  (exec_busy),
        .writeback  (writeback),
        .stall      (stall),
        .exec_req   (exec_req),
        .reg_values (sim_wb_value)
    );

    core_execute #(
        .core_id    (core_id)
    ) u_execute (
        .clk        (clk),
        .rst_n      (rst_n),
        .exec_req   (exec_req),
        .instret    (instret),
        .dcache_req (dcache_req),
        .dcache_rsp (dcache_rsp),
        .branch_ctl (branch_ctl),
        .alu_commit (alu_commit),
        .ld_commit  (ld_commit),
        .st_done    (st_done),
        .busy       (exec_busy),
        .sim_ebreak (sim_ebreak)
    );

    core_commit u_commit (
        .clk        (clk),
        .rst_n      (rst_n),
        .alu_commit (alu_commit),
        .ld_commit  (ld_commit),
        .st_done    (st_done),
        .writeback  (writeback),
        .instret    (instret)
    );

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# Build with Verilator, run, and look for the pass message in the output.
cd "$(dirname "$0")" \
    && verilator --binary --timing -f src.f --top-module core_tb -Mdir obj_dir \
    && ./obj_dir/Vcore_tb | tee /dev/stderr | grep -q "TESTS PASSED" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* src.f */
rtl/core_isa_pkg.sv
rtl/core_pipe_pkg.sv
rtl/core_fetch.sv
rtl/core_decode.sv
rtl/core_issue.sv
rtl/core_execute.sv
rtl/core_commit.sv
rtl/core_top.sv
dv/tb_mem_model.sv
dv/core_tb.sv
